/* rd_dma_pkg.sv */
/*
 * Shared definitions for the DMA read path
 *   - width constants for lengths, packet counts and data totals
 *   - read command, completion header and completion status structs
 *   - initial-burst table thresholds and divisors for read metering
 *   - idle value of the data high-water mark
 */
package rd_dma_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------
  localparam int DW_LEN_W   = 11;            // Max read length field
  localparam int PKT_CNT_W  = 16;            // Packets per job
  localparam int DW_TOTAL_W = 32;            // Running completion total

  typedef logic [DW_LEN_W-1:0]   dw_len_t;   // Length in DWs
  typedef logic [PKT_CNT_W-1:0]  pkt_cnt_t;  // Packet count
  typedef logic [DW_TOTAL_W-1:0] dw_total_t; // Received DWs

  // ----------------------------------------------------------
  // Structs
  // ----------------------------------------------------------
  typedef struct packed {
    pkt_cnt_t pkt_total;                     // MRd packets in the job
    dw_len_t  pkt_len;                       // DWs per MRd
    logic     rcb_128;                       // 0 = 64B RCB, 1 = 128B RCB
    logic     metering_en;                   // Gate issue by completions
  } rd_cmd_t;

  typedef struct packed {
    dw_len_t len_dw;                         // Completion payload size
    logic    malformed;                      // Bad TLP seen by the link
    logic    data_err;                       // Poisoned / bad data
  } cpl_hdr_t;

  typedef struct packed {
    dw_total_t data_total;                   // DWs received this job
    logic      malformed;                    // Sticky
    logic      data_err;                     // Sticky
  } cpl_status_t;

  // ----------------------------------------------------------
  // Read metering table
  // ----------------------------------------------------------
  localparam dw_len_t RCB64_HALF_MAX  = 11'd16;   // 64B RCB, half up to here
  localparam dw_len_t RCB64_QTR_MAX   = 11'd64;   // 64B RCB, quarter up to here
  localparam dw_len_t RCB128_HALF_MAX = 11'd32;   // 128B RCB, half up to here
  localparam dw_len_t RCB128_QTR_MAX  = 11'd128;  // 128B RCB, quarter up to here

  localparam int BURST_DIV_FULL    = 1;           // Single-DW reads
  localparam int BURST_DIV_HALF    = 2;
  localparam int BURST_DIV_QUARTER = 4;
  localparam int BURST_DIV_EIGHTH  = 8;           // Long reads

  localparam dw_total_t DATA_HWM_IDLE = '1;       // Data mark never met

endpackage

/* mrd_req_gen.sv */
/*
 * MRd request generator
 *   - job state, set by the start strobe, dropped after the last packet
 *   - issued-packet counter
 *   - registered one-cycle request pulse with its length
 */
module mrd_req_gen
  import rd_dma_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  input  logic     start_i,      // Job start strobe
  input  rd_cmd_t  cmd_i,        // Held for the whole job
  input  logic     issue_en_i,   // From the read metering unit

  output logic     mrd_req_o,    // One pulse per MRd
  output dw_len_t  mrd_len_o,    // Length of the current MRd
  output pkt_cnt_t pkt_count_o,  // MRds issued so far
  output logic     job_active_o  // Job in progress
);

  logic     job_active_q;
  pkt_cnt_t pkt_count_q;
  logic     mrd_req_q;
  dw_len_t  mrd_len_q;
  logic     all_sent;
  logic     fire;

  // ----------------------------------------------------------
  // Issue decision
  // ----------------------------------------------------------
  assign all_sent = (pkt_count_q >= cmd_i.pkt_total);          // Nothing left
  assign fire     = job_active_q & issue_en_i & ~all_sent;      // Send this cycle

  // ----------------------------------------------------------
  // Job state
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      job_active_q <= 1'b0;
    end else if (start_i) begin
      job_active_q <= (cmd_i.pkt_total != '0);                  // Empty job never runs
    end else if (job_active_q && all_sent) begin
      job_active_q <= 1'b0;                                     // Cycle after last pulse
    end
  end

  // ----------------------------------------------------------
  // Packet counter and request pulse
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pkt_count_q <= '0;
    end else if (start_i) begin
      pkt_count_q <= '0;                                        // New job
    end else if (fire) begin
      pkt_count_q <= pkt_count_q + 1'b1;                        // Same edge as pulse
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mrd_req_q <= 1'b0;
    end else begin
      mrd_req_q <= fire & ~start_i;                             // Restart drops the pulse
    end
  end

  // Length travels with the pulse
  always_ff @(posedge clk) begin
    if (fire) begin
      mrd_len_q <= cmd_i.pkt_len;
    end
  end

  assign mrd_req_o    = mrd_req_q;
  assign mrd_len_o    = mrd_len_q;
  assign pkt_count_o  = pkt_count_q;
  assign job_active_o = job_active_q;

endmodule

/* mrd_throttle.sv */
/*
 * Read metering unit
 *   - initial burst from the length / RCB table
 *   - packet and data high-water marks
 *   - registered completion-found flag
 *   - issue enable towards the request generator
 */
module mrd_throttle
  import rd_dma_pkg::*;
#(
  parameter int unsigned CPL_LIMIT = 8             // Multiple of 8
) (
  input  logic        clk,
  input  logic        rst_n,

  input  logic        init_i,                      // Job start, clears marks
  input  logic        job_active_i,                // From the generator
  input  rd_cmd_t     cmd_i,                       // Length, RCB, metering enable
  input  pkt_cnt_t    pkt_count_i,                 // MRds issued so far
  input  cpl_status_t status_i,                    // Completion feedback

  output logic        issue_en_o                   // MRd issue allowed
);

  // Burst sizes from the completion limit
  localparam pkt_cnt_t BURST_FULL    = pkt_cnt_t'(CPL_LIMIT / BURST_DIV_FULL);
  localparam pkt_cnt_t BURST_HALF    = pkt_cnt_t'(CPL_LIMIT / BURST_DIV_HALF);
  localparam pkt_cnt_t BURST_QUARTER = pkt_cnt_t'(CPL_LIMIT / BURST_DIV_QUARTER);
  localparam pkt_cnt_t BURST_EIGHTH  = pkt_cnt_t'(CPL_LIMIT / BURST_DIV_EIGHTH);

  pkt_cnt_t  pkt_hwm_q;                            // Read count allowed
  dw_total_t data_hwm_q;                           // Completion DWs needed
  logic      found_q;                              // Next packet covered
  pkt_cnt_t  burst;                                // Table lookup result
  logic      cpl_err;
  logic      found_cond;

  // ----------------------------------------------------------
  // Initial burst table
  // ----------------------------------------------------------
  function automatic pkt_cnt_t burst_of(input dw_len_t len, input logic rcb_128);
    dw_len_t half_max;
    dw_len_t qtr_max;
    half_max = rcb_128 ? RCB128_HALF_MAX : RCB64_HALF_MAX;
    qtr_max  = rcb_128 ? RCB128_QTR_MAX  : RCB64_QTR_MAX;
    if (len == dw_len_t'(1)) begin
      return BURST_FULL;                           // Single DW
    end else if (len <= half_max) begin
      return BURST_HALF;                           // Up to one RCB
    end else if (len <= qtr_max) begin
      return BURST_QUARTER;
    end else begin
      return BURST_EIGHTH;                         // Many completions per read
    end
  endfunction

  always_comb begin
    burst = burst_of(cmd_i.pkt_len, cmd_i.rcb_128);
  end

  assign cpl_err = status_i.malformed | status_i.data_err;

  // ----------------------------------------------------------
  // Completion found
  // ----------------------------------------------------------
  // Stalled one past the mark and the data for the mark has arrived
  assign found_cond = (pkt_count_i == pkt_hwm_q + 1'b1) &&
                      (status_i.data_total >= data_hwm_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      found_q <= 1'b0;
    end else if (init_i) begin
      found_q <= 1'b0;
    end else begin
      found_q <= found_cond & ~found_q;            // One shot per mark step
    end
  end

  // ----------------------------------------------------------
  // High-water marks
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pkt_hwm_q  <= '0;
      data_hwm_q <= DATA_HWM_IDLE;
    end else if (init_i) begin
      pkt_hwm_q  <= '0;
      data_hwm_q <= DATA_HWM_IDLE;
    end else if (job_active_i) begin
      if (pkt_hwm_q == '0) begin
        pkt_hwm_q  <= burst;                       // Initial burst
        data_hwm_q <= dw_total_t'(cmd_i.pkt_len);  // First packet's data
      end else if (cpl_err) begin
        pkt_hwm_q  <= '0;                          // Back to idle, burst reloads
        data_hwm_q <= DATA_HWM_IDLE;
      end else if (found_q) begin
        pkt_hwm_q  <= pkt_hwm_q + 1'b1;            // One more packet
        data_hwm_q <= data_hwm_q + dw_total_t'(cmd_i.pkt_len);
      end
    end
  end

  // ----------------------------------------------------------
  // Issue enable
  // ----------------------------------------------------------
  assign issue_en_o = cmd_i.metering_en ? (job_active_i & (pkt_hwm_q >= pkt_count_i))
                                        : job_active_i;

endmodule

/* cpl_fifo.sv */
/*
 * Completion header FIFO
 *   - circular buffer, first-word fall-through
 *   - occupancy count, registered full flag for back-pressure
 */
module cpl_fifo
  import rd_dma_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic     clk,
  input  logic     rst_n,

  input  logic     wr_i,             // Push, ignored when full
  input  cpl_hdr_t din_i,
  input  logic     rd_i,             // Pop, ignored when empty
  output cpl_hdr_t dout_o,           // Head entry
  output logic     empty_o,
  output logic     full_o
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  cpl_hdr_t         mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] count_nxt;
  logic             full_q;
  logic             push;
  logic             pop;

  assign push = wr_i & ~full_q;
  assign pop  = rd_i & (count_q != '0);

  // Pointer step with wrap at the depth
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_comb begin
    count_nxt = count_q;
    if (push && !pop) count_nxt = count_q + 1'b1;
    if (pop && !push) count_nxt = count_q - 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      full_q   <= 1'b1;                                   // No ready while in reset
    end else begin
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      count_q <= count_nxt;
      full_q  <= (count_nxt == CNT_W'(FIFO_DEPTH));
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr_q] <= din_i;
  end

  assign dout_o  = mem[rd_ptr_q];                         // Fall-through head
  assign empty_o = (count_q == '0);
  assign full_o  = full_q;

endmodule

/* cpl_accum.sv */
/*
 * Completion accumulator
 *   - pops the completion FIFO on every non-empty cycle
 *   - running total of received DWs
 *   - sticky malformed and data-error flags, cleared at job start
 */
module cpl_accum
  import rd_dma_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  input  logic        init_i,          // Job start
  input  logic        empty_i,         // FIFO empty
  input  cpl_hdr_t    cpl_i,           // FIFO head
  output logic        rd_o,            // FIFO pop
  output cpl_status_t status_o         // Feedback to metering
);

  cpl_status_t status_q;
  logic        pop;

  // ----------------------------------------------------------
  // Drain
  // ----------------------------------------------------------
  assign pop  = ~empty_i;                                   // Always ready to take
  assign rd_o = pop;

  // ----------------------------------------------------------
  // Total and flags
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status_q <= '0;
    end else if (init_i) begin
      status_q <= '0;                                       // Fresh job
    end else if (pop) begin
      status_q.data_total <= status_q.data_total + dw_total_t'(cpl_i.len_dw);
      status_q.malformed  <= status_q.malformed | cpl_i.malformed;  // Sticky
      status_q.data_err   <= status_q.data_err  | cpl_i.data_err;   // Sticky
    end
  end

  assign status_o = status_q;

endmodule

/* rd_dma_top.sv */
/*
 * DMA read path top level
 *   - request generator, read metering unit
 *   - completion FIFO and completion accumulator
 *   - ready, busy and error wiring
 */
module rd_dma_top
  import rd_dma_pkg::*;
#(
  parameter int unsigned CPL_LIMIT  = 8,     // Metering burst base
  parameter int unsigned FIFO_DEPTH = 4      // Completion buffer entries
) (
  input  logic      clk,
  input  logic      rst_n,

  input  logic      start_i,                 // Job start strobe
  input  rd_cmd_t   cmd_i,                   // Job command levels

  input  logic      cpl_valid_i,             // Completion offered
  input  cpl_hdr_t  cpl_i,
  output logic      cpl_ready_o,             // Buffer has room

  output logic      mrd_req_o,               // MRd pulse
  output dw_len_t   mrd_len_o,
  output logic      busy_o,
  output dw_total_t rx_total_o,              // DWs received this job
  output logic      err_o                    // Completion error seen
);

  // ----------------------------------------------------------
  // Internal wires
  // ----------------------------------------------------------
  logic        job_active;
  pkt_cnt_t    pkt_count;
  logic        issue_en;
  logic        fifo_full;
  logic        fifo_empty;
  logic        fifo_rd;
  cpl_hdr_t    fifo_head;
  cpl_status_t status;

  assign cpl_ready_o = ~fifo_full;
  assign busy_o      = job_active;
  assign rx_total_o  = status.data_total;
  assign err_o       = status.malformed | status.data_err;

  // ----------------------------------------------------------
  // Request side
  // ----------------------------------------------------------
  mrd_req_gen u_req_gen (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (start_i),
    .cmd_i        (cmd_i),
    .issue_en_i   (issue_en),
    .mrd_req_o    (mrd_req_o),
    .mrd_len_o    (mrd_len_o),
    .pkt_count_o  (pkt_count),
    .job_active_o (job_active)
  );

  mrd_throttle #(.CPL_LIMIT(CPL_LIMIT)) u_throttle (
    .clk          (clk),
    .rst_n        (rst_n),
    .init_i       (start_i),
    .job_active_i (job_active),
    .cmd_i        (cmd_i),
    .pkt_count_i  (pkt_count),
    .status_i     (status),
    .issue_en_o   (issue_en)
  );

  // ----------------------------------------------------------
  // Completion side
  // ----------------------------------------------------------
  cpl_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_cpl_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_i    (cpl_valid_i & cpl_ready_o),
    .din_i   (cpl_i),
    .rd_i    (fifo_rd),
    .dout_o  (fifo_head),
    .empty_o (fifo_empty),
    .full_o  (fifo_full)
  );

  cpl_accum u_cpl_accum (
    .clk      (clk),
    .rst_n    (rst_n),
    .init_i   (start_i),
    .empty_i  (fifo_empty),
    .cpl_i    (fifo_head),
    .rd_o     (fifo_rd),
    .status_o (status)
  );

endmodule

/* tb_rd_dma.sv */
/*
 * Testbench for the DMA read path
 *   - clock, reset and a completer model with random gaps
 *   - reference burst allowance and per-edge metering compare
 *   - job, table-edge, metering-off, error and back-pressure tests
 */
module tb_rd_dma
  import rd_dma_pkg::*;
();

  localparam int unsigned CPL_LIMIT  = 8;
  localparam int unsigned FIFO_DEPTH = 1;           // Back-to-back completions stall

  logic        clk;
  logic        rst_n;
  logic        start;
  rd_cmd_t     cmd;
  logic        cpl_valid;
  cpl_hdr_t    cpl;
  logic        cpl_ready;
  logic        mrd_req;
  dw_len_t     mrd_len;
  logic        busy;
  dw_total_t   rx_total;
  logic        err;

  dw_len_t     pend[$];                             // Reads awaiting completion
  int          issued;                              // Pulses seen this job
  int          stalls;                              // Offered while not ready
  logic [31:0] rng = 32'hebc7;
  bit          hold_cpl;                            // Withhold completions
  bit          back_to_back;                        // No gap between completions
  logic [1:0]  cpl_flags;                           // {malformed, data_err} for next one

  rd_dma_top #(.CPL_LIMIT(CPL_LIMIT), .FIFO_DEPTH(FIFO_DEPTH)) uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start),
    .cmd_i       (cmd),
    .cpl_valid_i (cpl_valid),
    .cpl_i       (cpl),
    .cpl_ready_o (cpl_ready),
    .mrd_req_o   (mrd_req),
    .mrd_len_o   (mrd_len),
    .busy_o      (busy),
    .rx_total_o  (rx_total),
    .err_o       (err)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ----------------------------------------------------------
  // Reference model and checking
  // ----------------------------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Initial burst in packets, by length and RCB
  function automatic int burst_allow(input int len, input bit rcb_128);
    int rcb_dw;
    rcb_dw = rcb_128 ? 32 : 16;                     // DWs in one RCB
    if (len == 1) return CPL_LIMIT;
    else if (len <= rcb_dw) return CPL_LIMIT / 2;
    else if (len <= 4 * rcb_dw) return CPL_LIMIT / 4;
    else return CPL_LIMIT / 8;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic expect_eq(input string what, input longint got, input longint exp);
    if (got != exp) begin
      abort_run($sformatf("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  // Pulse count, length and outstanding bound on every edge
  always @(posedge clk) begin : compare
    int bound;
    if (start) begin
      issued = 0;
      pend.delete();                                // Old job's reads dropped
    end else if (rst_n) begin
      if (mrd_req) begin
        issued++;
        pend.push_back(mrd_len);
        expect_eq("mrd_len_o", mrd_len, cmd.pkt_len);
      end
      if (cmd.metering_en && cmd.pkt_len != '0) begin
        bound = burst_allow(cmd.pkt_len, cmd.rcb_128) + 1 + int'(rx_total / cmd.pkt_len);
        expect_eq("issued within metering bound", issued <= bound, 1);
      end
    end
  end

  // ----------------------------------------------------------
  // Completer model
  // ----------------------------------------------------------
  initial begin : completer
    int gap;
    int tries;
    cpl_valid = 1'b0;
    cpl       = '0;
    forever begin
      @(negedge clk);
      cpl_valid = 1'b0;
      if (!hold_cpl && pend.size() != 0) begin
        rng = xorshift(rng);
        gap = back_to_back ? 0 : int'(rng % 32'd8);
        repeat (gap) @(negedge clk);
        if (!hold_cpl && pend.size() != 0) begin  // Job may have restarted
          cpl.len_dw    = pend.pop_front();         // One completion per read
          cpl.malformed = cpl_flags[1];
          cpl.data_err  = cpl_flags[0];
          cpl_valid     = 1'b1;
          tries = 0;
          @(posedge clk);
          while (!cpl_ready) begin                  // Hold until accepted
            stalls++;
            tries++;
            if (tries > 100) abort_run("Timeout: completion never accepted by the DUT");
            @(posedge clk);
          end
          cpl_flags = 2'b00;
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Job control and waits
  // ----------------------------------------------------------
  task automatic start_job(input int total, input int len, input bit rcb_128, input bit meter);
    @(negedge clk);
    cmd.pkt_total   = pkt_cnt_t'(total);
    cmd.pkt_len     = dw_len_t'(len);
    cmd.rcb_128     = rcb_128;
    cmd.metering_en = meter;
    start           = 1'b1;
    @(negedge clk);
    start           = 1'b0;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy) begin
      @(negedge clk);
      n++;
      if (n > 3000) abort_run("Timeout waiting for busy_o to fall");
    end
  endtask

  task automatic wait_issued(input int exp);
    int n;
    n = 0;
    while (issued < exp) begin
      @(negedge clk);
      n++;
      if (n > 200) abort_run("Timeout waiting for read requests to be issued");
    end
  endtask

  task automatic wait_total(input longint exp);
    int n;
    n = 0;
    while (rx_total < exp) begin
      @(negedge clk);
      n++;
      if (n > 3000) abort_run("Timeout waiting for all completion data to arrive");
    end
  endtask

  task automatic wait_err();
    int n;
    n = 0;
    while (!err) begin
      @(negedge clk);
      n++;
      if (n > 500) abort_run("Timeout waiting for err_o after a bad completion");
    end
  endtask

  task automatic run_job(input int total, input int len, input bit rcb_128);
    start_job(total, len, rcb_128, 1'b1);
    wait_idle();
    expect_eq("request count", issued, total);
    wait_total(total * len);
    expect_eq("rx_total_o", rx_total, total * len);
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin : test_seq
    int lens[9];
    int exp;
    rst_n = 1'b0;
    start = 1'b0;
    cmd   = '0;
    cpl_flags = 2'b00;
    repeat (3) @(posedge clk);                      // Reset for 3 cycles
    expect_eq("outputs in reset", {mrd_req, busy, err, cpl_ready}, 0);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    expect_eq("cpl_ready_o after reset", cpl_ready, 1);

    for (int r = 0; r < 2; r++) begin               // Full jobs, both RCBs
      run_job(12, 1, r);
      run_job(12, 8, r);
      run_job(12, 40, r);
      run_job(10, 150, r);
    end

    back_to_back = 1'b1;                            // Single-entry FIFO fills
    stalls = 0;
    run_job(16, 4, 1'b0);
    expect_eq("cpl_ready_o low under back-to-back load", stalls > 0, 1);
    back_to_back = 1'b0;

    hold_cpl = 1'b1;                                // Table edges, no completions
    lens = '{1, 16, 17, 32, 33, 64, 65, 128, 129};
    foreach (lens[i]) begin
      for (int r = 0; r < 2; r++) begin
        exp = burst_allow(lens[i], r) + 1;
        start_job(20, lens[i], r, 1'b1);
        wait_issued(exp);
        repeat (20) @(negedge clk);                 // Must stay stalled
        expect_eq("requests with completions withheld", issued, exp);
        expect_eq("busy_o while stalled", busy, 1);
      end
    end

    start_job(20, 33, 1'b0, 1'b0);                  // Metering off
    wait_idle();
    expect_eq("requests with metering off", issued, 20);

    for (int f = 1; f < 3; f++) begin               // Data error, then malformed
      start_job(4, 8, 1'b0, 1'b1);
      cpl_flags = 2'(f);
      hold_cpl  = 1'b0;
      wait_err();
      hold_cpl  = 1'b1;
      repeat (10) begin
        @(negedge clk);
        expect_eq("err_o sticky", err, 1);
      end
      start_job(0, 8, 1'b0, 1'b1);                  // Empty job just clears
      expect_eq("err_o after restart", err, 0);
      expect_eq("rx_total_o after restart", rx_total, 0);
    end

    $display(">>> PASS");
    $finish;
  end

endmodule

/* sources.f */
rd_dma_pkg.sv
mrd_req_gen.sv
mrd_throttle.sv
cpl_fifo.sv
cpl_accum.sv
rd_dma_top.sv
tb_rd_dma.sv

/* run.sh */
#!/bin/sh
# Build and run the DMA read path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_rd_dma -f sources.f

status=0
./obj_dir/Vtb_rd_dma | tee /dev/stderr | grep -x -- '>>> PASS' > /dev/null || status=1
if [ "$status" -ne 0 ]; then
  echo "Simulation did not pass"
  exit 1
fi
